// File: rtl/dcache_pkg.sv
package dcache_pkg;

    localparam int XLEN        = 32;                  // word width
    localparam int SET_BITS    = 3;                   // 8 sets
    localparam int OFFSET_BITS = 2;                   // byte offset in a word
    localparam int TAG_BITS    = XLEN - SET_BITS - OFFSET_BITS;
    localparam int NUM_SETS    = 1 << SET_BITS;

    // cache view of an address, msb first
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [SET_BITS-1:0]    set;
        logic [OFFSET_BITS-1:0] offset;               // always 0 for word access
    } addr_fields_t;

    // same 32 bits, raw for memory indexing or split for lookup
    typedef union packed {
        logic [XLEN-1:0] raw;
        addr_fields_t    f;
    } addr_u;

endpackage

// File: rtl/dcache_if.sv
`timescale 1ns/1ps

interface dcache_if;

    logic [dcache_pkg::SET_BITS-1:0] set;       // selected line
    logic [dcache_pkg::TAG_BITS-1:0] tag;       // tag to compare / write
    logic                            fill_en;   // write valid, tag and word
    logic                            store_en;  // rewrite word only
    logic [dcache_pkg::XLEN-1:0]     line_data; // word to write
    logic                            hit;       // comb lookup result
    logic [dcache_pkg::XLEN-1:0]     line_word; // comb word of selected line

    modport ctrl (
        output set,
        output tag,
        output fill_en,
        output store_en,
        output line_data,
        input  hit,
        input  line_word
    );

    modport array (
        input  set,
        input  tag,
        input  fill_en,
        input  store_en,
        input  line_data,
        output hit,
        output line_word
    );

endinterface

// File: rtl/dcache_array.sv
`timescale 1ns/1ps

module dcache_array (
    input logic     clk,
    input logic     rst,
    dcache_if.array cif
);

    logic [dcache_pkg::NUM_SETS-1:0] valid;                         // one per set
    logic [dcache_pkg::TAG_BITS-1:0] tags  [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::XLEN-1:0]     words [dcache_pkg::NUM_SETS];

    // valid bits are the only state cleared by reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;                          // all lines invalid in one cycle
        end else if (cif.fill_en) begin
            valid[cif.set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cif.fill_en) begin
            tags[cif.set]  <= cif.tag;            // new owner of the line
            words[cif.set] <= cif.line_data;
        end else if (cif.store_en) begin
            words[cif.set] <= cif.line_data;      // tag already matches
        end
    end

    // lookup is purely combinational on the selected set
    assign cif.hit       = valid[cif.set] && (tags[cif.set] == cif.tag);
    assign cif.line_word = words[cif.set];

endmodule

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rd_en,
    input  logic                           wr_en,
    input  logic [dcache_pkg::XLEN-1:0]    addr,
    input  logic [dcache_pkg::XLEN-1:0]    wdata,
    input  logic [dcache_pkg::XLEN-1:0]    mem_rdata,
    output logic [dcache_pkg::XLEN-1:0]    rdata,
    output logic                           hit,
    output logic                           done,
    output logic                           busy,
    output logic                           mem_rd,
    output logic                           mem_wr,
    output logic [MEM_ADDR_BITS-1:0]       mem_addr,
    output logic [dcache_pkg::XLEN-1:0]    mem_wdata,
    dcache_if.ctrl                         cif
);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_MISS_RD   = 2'd1;   // mem_rd pulse
    localparam logic [1:0] ST_MISS_FILL = 2'd2;   // memory word back, fill line

    logic [1:0]                  state;
    dcache_pkg::addr_u           in_addr;         // request as it arrives
    dcache_pkg::addr_u           req_addr;        // latched request
    dcache_pkg::addr_u           look_addr;       // address seen by the array
    logic [dcache_pkg::XLEN-1:0] req_wdata;
    logic                        accept;

    assign in_addr.raw = addr;
    assign busy        = done || (state != ST_IDLE);
    assign accept      = !busy && (rd_en || wr_en);

    // while idle the array looks up the incoming address, so a hit answers next cycle
    assign look_addr = busy ? req_addr : in_addr;

    assign cif.set       = look_addr.f.set;
    assign cif.tag       = look_addr.f.tag;
    assign cif.fill_en   = (state == ST_MISS_FILL);
    assign cif.store_en  = mem_wr && cif.hit;     // write-through, no allocate
    assign cif.line_data = cif.fill_en ? mem_rdata : req_wdata;

    assign mem_rd    = (state == ST_MISS_RD);
    assign mem_addr  = req_addr.raw[MEM_ADDR_BITS+dcache_pkg::OFFSET_BITS-1:
                                    dcache_pkg::OFFSET_BITS];   // word index
    assign mem_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done   <= 1'b0;
            mem_wr <= 1'b0;
        end else begin
            done   <= 1'b0;                       // pulses by default
            mem_wr <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept && rd_en) begin
                        if (cif.hit) begin
                            done <= 1'b1;
                        end else begin
                            state <= ST_MISS_RD;
                        end
                    end else if (accept) begin
                        mem_wr <= 1'b1;           // store answers in one cycle
                        done   <= 1'b1;
                    end
                end
                ST_MISS_RD: begin
                    state <= ST_MISS_FILL;
                end
                ST_MISS_FILL: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= in_addr;
            req_wdata <= wdata;
            hit       <= cif.hit;                 // lookup result for load or store
        end
        if (accept && rd_en && cif.hit) begin
            rdata <= cif.line_word;
        end else if (state == ST_MISS_FILL) begin
            rdata <= mem_rdata;
        end
    end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                        clk,
    input  logic                        mem_rd,
    input  logic                        mem_wr,
    input  logic [MEM_ADDR_BITS-1:0]    mem_addr,
    input  logic [dcache_pkg::XLEN-1:0] mem_wdata,
    output logic [dcache_pkg::XLEN-1:0] mem_rdata
);

    logic [dcache_pkg::XLEN-1:0] mem [2**MEM_ADDR_BITS];   // word addressed

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] <= mem_wdata;
        end
        if (mem_rd) begin
            mem_rdata <= mem[mem_addr];           // valid the cycle after mem_rd
        end
    end

endmodule

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rd_en,
    input  logic                        wr_en,
    input  logic [dcache_pkg::XLEN-1:0] addr,
    input  logic [dcache_pkg::XLEN-1:0] wdata,
    output logic [dcache_pkg::XLEN-1:0] rdata,
    output logic                        hit,
    output logic                        done,
    output logic                        busy
);

    logic                        mem_rd;
    logic                        mem_wr;
    logic [MEM_ADDR_BITS-1:0]    mem_addr;
    logic [dcache_pkg::XLEN-1:0] mem_wdata;
    logic [dcache_pkg::XLEN-1:0] mem_rdata;

    dcache_if cif ();

    dcache_ctrl #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) dcache_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .rd_en     (rd_en),
        .wr_en     (wr_en),
        .addr      (addr),
        .wdata     (wdata),
        .mem_rdata (mem_rdata),
        .rdata     (rdata),
        .hit       (hit),
        .done      (done),
        .busy      (busy),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .cif       (cif.ctrl)
    );

    dcache_array dcache_array_i (
        .clk (clk),
        .rst (rst),
        .cif (cif.array)
    );

    data_mem #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) data_mem_i (
        .clk       (clk),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;          // half period high, half low
        end
    end

endmodule

// File: bench/dcache_asserts.sv
`timescale 1ns/1ps

module dcache_asserts (
    input logic clk,
    input logic rst,
    input logic done,
    input logic busy,
    input logic mem_rd,
    input logic mem_wr,
    input logic fill_en
);

    int fail_count = 0;                           // read by the testbench at the end

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    mem_exclusive: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
        else begin
            $error("mem_rd and mem_wr high in the same cycle");
            fail_count++;
        end

    fill_after_read: assert property (@(posedge clk) disable iff (rst) fill_en |-> $past(mem_rd))
        else begin
            $error("fill_en without mem_rd in the cycle before");
            fail_count++;
        end

    idle_after_reset: assert property (@(posedge clk) rst |=> !busy)
        else begin
            $error("busy high right after reset");
            fail_count++;
        end

endmodule

bind dcache_ctrl dcache_asserts dcache_asserts_i (
    .clk     (clk),
    .rst     (rst),
    .done    (done),
    .busy    (busy),
    .mem_rd  (mem_rd),
    .mem_wr  (mem_wr),
    .fill_en (cif.fill_en)
);

// File: bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int          MAX_CASES      = 64;
    localparam int          WORDS_PER_CASE = 5;     // op, addr, wdata, rdata, hit
    localparam logic [31:0] OP_LOAD        = 32'h0;
    localparam logic [31:0] OP_STORE       = 32'h1;
    localparam logic [31:0] OP_RESET       = 32'h2;
    localparam logic [31:0] OP_END         = 32'hff;

    logic                        clk;
    logic                        rst;
    logic                        rd_en;
    logic                        wr_en;
    logic [dcache_pkg::XLEN-1:0] addr;
    logic [dcache_pkg::XLEN-1:0] wdata;
    logic [dcache_pkg::XLEN-1:0] rdata;
    logic                        hit;
    logic                        done;
    logic                        busy;

    logic [31:0] case_words [MAX_CASES*WORDS_PER_CASE];
    int          num_cases    = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 0;                  // 0 until the cases are counted
    int          errors       = 0;
    int          failed_cases = 0;

    tb_clock_gen #(
        .PERIOD_NS (8)
    ) clock_gen_i (
        .clk (clk)
    );

    dcache_top #(
        .MEM_ADDR_BITS (10)
    ) dcache_top_i (
        .clk   (clk),
        .rst   (rst),
        .rd_en (rd_en),
        .wr_en (wr_en),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .hit   (hit),
        .done  (done),
        .busy  (busy)
    );

    // watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not end within %0d cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // strobe an idle DUT once and follow busy until done at falling edges
    task automatic run_access(input logic [31:0] op, input logic [31:0] a,
                              input logic [31:0] d, output int busy_errors);
        busy_errors = 0;
        @(negedge clk);
        assert (busy == 1'b0) else begin
            $display("error at %0t: busy is %b, expected %b", $time, busy, 1'b0);
            busy_errors++;
        end
        @(posedge clk);
        rd_en <= (op == OP_LOAD);
        wr_en <= (op == OP_STORE);
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        rd_en <= 1'b0;
        wr_en <= 1'b0;
        do begin
            @(negedge clk);
            assert (busy == 1'b1) else begin
                $display("error at %0t: busy is %b, expected %b", $time, busy, 1'b1);
                busy_errors++;
            end
        end while (!done);
    endtask

    task automatic check_response(input logic is_load, input logic [31:0] exp_rdata,
                                  input logic exp_hit, output int case_errors);
        case_errors = 0;
        if (is_load) begin
            assert (rdata == exp_rdata) else begin
                $display("error at %0t: rdata is %h, expected %h", $time, rdata, exp_rdata);
                case_errors++;
            end
        end
        assert (hit == exp_hit) else begin
            $display("error at %0t: hit is %b, expected %b", $time, hit, exp_hit);
            case_errors++;
        end
    endtask

    task automatic pulse_reset(input int cycles);
        @(posedge clk);
        rst <= 1'b1;
        repeat (cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    initial begin
        int          case_errors;
        int          access_errors;
        int          base;
        logic [31:0] op;
        string       op_name;

        rst   = 1'b1;
        rd_en = 1'b0;
        wr_en = 1'b0;
        addr  = '0;
        wdata = '0;
        foreach (case_words[i]) begin
            case_words[i] = OP_END;               // a missing file reads as no cases
        end
        $readmemh("bench/dcache_cases.txt", case_words);
        while (num_cases < MAX_CASES && case_words[num_cases*WORDS_PER_CASE] != OP_END) begin
            num_cases++;
        end
        cycle_limit = num_cases * 8 + 50;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        assert (num_cases > 0) else begin
            $display("no cases could be read from bench/dcache_cases.txt");
            errors++;
        end

        for (int n = 0; n < num_cases; n++) begin
            base        = n * WORDS_PER_CASE;
            op          = case_words[base];
            case_errors = 0;
            if (op == OP_RESET) begin
                op_name = "reset";
                pulse_reset(2);
            end else if (op == OP_LOAD || op == OP_STORE) begin
                op_name = (op == OP_LOAD) ? "load" : "store";
                run_access(op, case_words[base+1], case_words[base+2], access_errors);
                check_response(op == OP_LOAD, case_words[base+3], case_words[base+4][0],
                               case_errors);
                case_errors += access_errors;
            end else begin
                op_name = "unknown";
                $display("case %0d has an operation code the testbench does not know", n);
                case_errors = 1;
            end
            errors += case_errors;
            if (case_errors != 0) begin
                failed_cases++;
            end
            $display("case %0d %s addr %h: %s", n, op_name, case_words[base+1],
                     (case_errors == 0) ? "ok" : "FAILED");
        end

        repeat (2) @(posedge clk);                // let late assertion failures land
        errors += dcache_top_i.dcache_ctrl_i.dcache_asserts_i.fail_count;
        $display("cases: %0d, failed cases: %0d, assertion failures: %0d, errors: %0d",
                 num_cases, failed_cases,
                 dcache_top_i.dcache_ctrl_i.dcache_asserts_i.fail_count, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: bench/dcache_cases.txt
// op addr wdata exp_rdata exp_hit, all hex
// op 0 load, 1 store, 2 reset, ff end of list
1 00000004 11111111 00000000 0
1 00000024 22222222 00000000 0
1 00000008 33333333 00000000 0
1 0000010c 44444444 00000000 0
1 00000010 55555555 00000000 0
0 00000004 00000000 11111111 0
0 00000004 00000000 11111111 1
0 00000024 00000000 22222222 0
0 00000024 00000000 22222222 1
0 00000004 00000000 11111111 0
0 00000008 00000000 33333333 0
1 00000008 a5a5a5a5 00000000 1
0 00000008 00000000 a5a5a5a5 1
1 00000018 66666666 00000000 0
0 00000018 00000000 66666666 0
0 00000018 00000000 66666666 1
1 00000024 77777777 00000000 0
0 00000004 00000000 11111111 1
0 00000024 00000000 77777777 0
0 0000010c 00000000 44444444 0
0 0000010c 00000000 44444444 1
2 00000000 00000000 00000000 0
0 0000010c 00000000 44444444 0
0 00000008 00000000 a5a5a5a5 0
0 00000024 00000000 77777777 0
0 00000018 00000000 66666666 0
0 00000010 00000000 55555555 0
0 00000008 00000000 a5a5a5a5 1
ff 00000000 00000000 00000000 0

// File: filelist.f
rtl/dcache_pkg.sv
rtl/dcache_if.sv
rtl/dcache_array.sv
rtl/dcache_ctrl.sv
rtl/data_mem.sv
rtl/dcache_top.sv
bench/tb_clock_gen.sv
bench/dcache_asserts.sv
bench/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the dcache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module dcache_tb \
    --Mdir "$build_dir" -o dcache_sim \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
"./$build_dir/dcache_sim" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Finished with no errors" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
